// ==== Makefile ====
# Verilator simulation of the pipeline control subsystem
TOP = tb_pipe_ctrl

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== src.f ====
+incdir+verilog
verilog/riscv_pkg.sv
verilog/hazard_unit.sv
verilog/stage_tracker.sv
verilog/forward_unit.sv
verilog/pipe_ctrl_top.sv
testbench/tb_clock.sv
testbench/tb_pipe_ctrl.sv

// ==== testbench/tb_clock.sv ====
//****************************************
// Testbench clock and reset
// 100 unit clock, active-low reset held
// for the first two rising edges
//****************************************
`default_nettype none

module tb_clock (
    output logic CLK,
    output logic RSTn
);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    initial begin
        RSTn <= 1'b0;
        repeat (2) @(posedge CLK);
        RSTn <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_pipe_ctrl.sv ====
//****************************************
// Pipeline control testbench
// Random and directed stimulus against a
// shadow model of the memory-wait FSM and
// the three descriptor slots
//****************************************
`include "riscv_ctrl_params.svh"
`default_nettype none

module tb_pipe_ctrl;

    localparam int IDLE_CYCLES     = 4;
    localparam int STALL_BURSTS    = 12;
    localparam int BURST_MAX       = 8;
    localparam int BURST_GAP       = 2;
    localparam int DIRECTED_CYCLES = 16;
    localparam int FWD_CYCLES      = 200;
    localparam int MAX_CYCLES      = 2 + 3 * IDLE_CYCLES + DIRECTED_CYCLES + FWD_CYCLES +
                                     STALL_BURSTS * (BURST_MAX + BURST_GAP) + 50;

    logic CLK;
    logic RSTn;

    logic                    dec_valid;
    riscv_pkg::reg_idx_t     dec_rs1;
    riscv_pkg::reg_idx_t     dec_rs2;
    riscv_pkg::reg_idx_t     dec_rd;
    logic                    dec_reg_write;
    logic                    dec_is_load;
    logic                    jump;
    logic                    instr_busy;
    logic                    data_busy;
    logic                    instr_req;
    logic                    data_req;
    riscv_pkg::hazard_ctrl_t pc_ctrl;
    riscv_pkg::hazard_ctrl_t if_dec_ctrl;
    riscv_pkg::hazard_ctrl_t dec_ex_ctrl;
    riscv_pkg::hazard_ctrl_t ex_mem_ctrl;
    riscv_pkg::hazard_ctrl_t mem_wb_ctrl;
    riscv_pkg::fwd_sel_t     fwd_a;
    riscv_pkg::fwd_sel_t     fwd_b;

    // Shadow of the memory-wait FSM
    typedef enum logic [1:0] {M_ISSUE, M_IWAIT, M_DWAIT, M_BWAIT} mstate_t;
    mstate_t m_state;

    // Shadow descriptor slots
    logic                m_ex_v;
    logic                m_ex_wr;
    logic                m_ex_ld;
    riscv_pkg::reg_idx_t m_ex_rs1;
    riscv_pkg::reg_idx_t m_ex_rs2;
    riscv_pkg::reg_idx_t m_ex_rd;
    logic                m_mem_v;
    logic                m_mem_wr;
    riscv_pkg::reg_idx_t m_mem_rd;
    logic                m_wb_v;
    logic                m_wb_wr;
    riscv_pkg::reg_idx_t m_wb_rd;

    // Expected DUT outputs
    riscv_pkg::hazard_ctrl_t e_pc;
    riscv_pkg::hazard_ctrl_t e_ifd;
    riscv_pkg::hazard_ctrl_t e_dex;
    riscv_pkg::hazard_ctrl_t e_exm;
    riscv_pkg::hazard_ctrl_t e_mwb;
    riscv_pkg::hazard_ctrl_t base;
    logic                    e_ireq;
    logic                    e_dreq;
    riscv_pkg::fwd_sel_t     e_fa;
    riscv_pkg::fwd_sel_t     e_fb;
    logic                    wait_hold;
    logic                    stall_all;
    logic                    load_hit;
    logic                    mem_src;
    logic                    wb_src;

    // How often the interesting cases were hit
    int n_load_use;
    int n_wait;
    int n_fwd_mem;
    int n_fwd_wb;
    int cycle_cnt;

    logic [15:0] lfsr = 16'd14;

    tb_clock i_clock (
        .CLK  (CLK),
        .RSTn (RSTn)
    );

    pipe_ctrl_top i_dut (
        .CLK           (CLK),
        .RSTn          (RSTn),
        .dec_valid     (dec_valid),
        .dec_rs1       (dec_rs1),
        .dec_rs2       (dec_rs2),
        .dec_rd        (dec_rd),
        .dec_reg_write (dec_reg_write),
        .dec_is_load   (dec_is_load),
        .jump          (jump),
        .instr_busy    (instr_busy),
        .data_busy     (data_busy),
        .instr_req     (instr_req),
        .data_req      (data_req),
        .pc_ctrl       (pc_ctrl),
        .if_dec_ctrl   (if_dec_ctrl),
        .dec_ex_ctrl   (dec_ex_ctrl),
        .ex_mem_ctrl   (ex_mem_ctrl),
        .mem_wb_ctrl   (mem_wb_ctrl),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b)
    );

    // Stage controls and requests from the hazard rules
    always_comb begin
        wait_hold = ((m_state == M_IWAIT) && instr_busy) ||
                    ((m_state == M_DWAIT) && data_busy) ||
                    ((m_state == M_BWAIT) && (instr_busy || data_busy));
        stall_all = wait_hold || ((m_state == M_ISSUE) && instr_busy);
        load_hit  = (m_state == M_ISSUE) && m_ex_v && m_ex_ld && (m_ex_rd != '0) &&
                    dec_valid && ((dec_rs1 == m_ex_rd) || (dec_rs2 == m_ex_rd));
        base   = stall_all ? `HZ_STALL : `HZ_ENABLE;
        e_pc   = base;
        e_ifd  = base;
        e_dex  = base;
        e_exm  = base;
        e_mwb  = base;
        e_ireq = !wait_hold;
        e_dreq = !wait_hold;
        if (!stall_all && jump && (m_state == M_ISSUE)) begin
            e_ifd = `HZ_FLUSH;
        end
        // Fetch returns on the wrong path
        if ((m_state == M_IWAIT) && !instr_busy && jump) begin
            e_pc  = `HZ_STALL;
            e_ifd = `HZ_FLUSH;
        end
        if (load_hit) begin
            e_pc  = `HZ_STALL;
            e_ifd = `HZ_STALL;
            e_dex = `HZ_FLUSH;
        end
    end

    // Operand sources, younger writer first
    always_comb begin
        mem_src = m_mem_v && m_mem_wr && (m_mem_rd != '0);
        wb_src  = m_wb_v && m_wb_wr && (m_wb_rd != '0);
        e_fa    = `FWD_REG;
        e_fb    = `FWD_REG;
        if (m_ex_v && mem_src && (m_mem_rd == m_ex_rs1)) begin
            e_fa = `FWD_MEM;
        end else if (m_ex_v && wb_src && (m_wb_rd == m_ex_rs1)) begin
            e_fa = `FWD_WB;
        end
        if (m_ex_v && mem_src && (m_mem_rd == m_ex_rs2)) begin
            e_fb = `FWD_MEM;
        end else if (m_ex_v && wb_src && (m_wb_rd == m_ex_rs2)) begin
            e_fb = `FWD_WB;
        end
    end

    always @(posedge CLK) begin
        if (!RSTn) begin
            m_state    <= M_ISSUE;
            m_ex_v     <= 1'b0;
            m_ex_wr    <= 1'b0;
            m_ex_ld    <= 1'b0;
            m_ex_rs1   <= '0;
            m_ex_rs2   <= '0;
            m_ex_rd    <= '0;
            m_mem_v    <= 1'b0;
            m_mem_wr   <= 1'b0;
            m_mem_rd   <= '0;
            m_wb_v     <= 1'b0;
            m_wb_wr    <= 1'b0;
            m_wb_rd    <= '0;
            n_load_use <= 0;
            n_wait     <= 0;
            n_fwd_mem  <= 0;
            n_fwd_wb   <= 0;
        end else begin
            case (m_state)
                M_ISSUE: m_state <= instr_busy ? (data_busy ? M_BWAIT : M_IWAIT) :
                                    (data_busy ? M_DWAIT : M_ISSUE);
                M_IWAIT: m_state <= instr_busy ? M_IWAIT : M_ISSUE;
                M_DWAIT: m_state <= data_busy ? M_DWAIT : M_ISSUE;
                default: m_state <= instr_busy ? M_IWAIT : (data_busy ? M_DWAIT : M_ISSUE);
            endcase
            if (e_dex == `HZ_ENABLE) begin
                m_ex_v   <= dec_valid;
                m_ex_wr  <= dec_reg_write;
                m_ex_ld  <= dec_is_load;
                m_ex_rs1 <= dec_rs1;
                m_ex_rs2 <= dec_rs2;
                m_ex_rd  <= dec_rd;
            end else if (e_dex == `HZ_FLUSH) begin
                m_ex_v <= 1'b0;
            end
            if (e_exm == `HZ_ENABLE) begin
                m_mem_v  <= m_ex_v;
                m_mem_wr <= m_ex_wr;
                m_mem_rd <= m_ex_rd;
            end
            if (e_mwb == `HZ_ENABLE) begin
                m_wb_v  <= m_mem_v;
                m_wb_wr <= m_mem_wr;
                m_wb_rd <= m_mem_rd;
            end
            n_load_use <= n_load_use + (load_hit ? 1 : 0);
            n_wait     <= n_wait + (wait_hold ? 1 : 0);
            n_fwd_mem  <= n_fwd_mem + ((e_fa == `FWD_MEM || e_fb == `FWD_MEM) ? 1 : 0);
            n_fwd_wb   <= n_fwd_wb + ((e_fa == `FWD_WB || e_fb == `FWD_WB) ? 1 : 0);
        end
    end

    task automatic report_mismatch(
        input string      sig,
        input logic [1:0] exp_v,
        input logic [1:0] act_v
    );
        $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, sig, exp_v, act_v);
        $display("TB FAILED");
        $fatal(1, "%s mismatch", sig);
    endtask

    a_pc_ctrl: assert property (@(posedge CLK) disable iff (!RSTn) pc_ctrl == e_pc)
        else report_mismatch("pc_ctrl", $sampled(e_pc), $sampled(pc_ctrl));
    a_if_dec_ctrl: assert property (@(posedge CLK) disable iff (!RSTn) if_dec_ctrl == e_ifd)
        else report_mismatch("if_dec_ctrl", $sampled(e_ifd), $sampled(if_dec_ctrl));
    a_dec_ex_ctrl: assert property (@(posedge CLK) disable iff (!RSTn) dec_ex_ctrl == e_dex)
        else report_mismatch("dec_ex_ctrl", $sampled(e_dex), $sampled(dec_ex_ctrl));
    a_ex_mem_ctrl: assert property (@(posedge CLK) disable iff (!RSTn) ex_mem_ctrl == e_exm)
        else report_mismatch("ex_mem_ctrl", $sampled(e_exm), $sampled(ex_mem_ctrl));
    a_mem_wb_ctrl: assert property (@(posedge CLK) disable iff (!RSTn) mem_wb_ctrl == e_mwb)
        else report_mismatch("mem_wb_ctrl", $sampled(e_mwb), $sampled(mem_wb_ctrl));
    a_instr_req: assert property (@(posedge CLK) disable iff (!RSTn) instr_req == e_ireq)
        else report_mismatch("instr_req", {1'b0, $sampled(e_ireq)}, {1'b0, $sampled(instr_req)});
    a_data_req: assert property (@(posedge CLK) disable iff (!RSTn) data_req == e_dreq)
        else report_mismatch("data_req", {1'b0, $sampled(e_dreq)}, {1'b0, $sampled(data_req)});
    a_fwd_a: assert property (@(posedge CLK) disable iff (!RSTn) fwd_a == e_fa)
        else report_mismatch("fwd_a", $sampled(e_fa), $sampled(fwd_a));
    a_fwd_b: assert property (@(posedge CLK) disable iff (!RSTn) fwd_b == e_fb)
        else report_mismatch("fwd_b", $sampled(e_fb), $sampled(fwd_b));

    // Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    task automatic set_decode(
        input logic                v,
        input riscv_pkg::reg_idx_t rs1,
        input riscv_pkg::reg_idx_t rs2,
        input riscv_pkg::reg_idx_t rd,
        input logic                wr,
        input logic                ld
    );
        dec_valid     <= v;
        dec_rs1       <= rs1;
        dec_rs2       <= rs2;
        dec_rd        <= rd;
        dec_reg_write <= wr;
        dec_is_load   <= ld;
    endtask

    task automatic clear_inputs();
        set_decode(1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0);
        jump       <= 1'b0;
        instr_busy <= 1'b0;
        data_busy  <= 1'b0;
    endtask

    // Registers x0..x7 only, so that slots collide often
    task automatic random_decode();
        logic [7:0] v;
        logic [7:0] rs1;
        logic [7:0] rs2;
        logic [7:0] rd;
        logic [7:0] wr;
        logic [7:0] ld;
        v   = take_bits(2);
        rs1 = take_bits(3);
        rs2 = take_bits(3);
        rd  = take_bits(3);
        wr  = take_bits(1);
        ld  = take_bits(2);
        set_decode(v != 8'd0, rs1[4:0], rs2[4:0], rd[4:0], wr[0], ld == 8'd3);
    endtask

    task automatic stall_bursts();
        logic [7:0] kind;
        int         len;
        for (int b = 0; b < STALL_BURSTS; b++) begin
            kind = take_bits(2);
            len  = int'(take_bits(3)) + 1;
            // 1 instruction side, 2 data side, else both
            for (int c = 0; c < len; c++) begin
                @(posedge CLK);
                instr_busy <= (kind != 8'd2);
                data_busy  <= (kind != 8'd1);
                random_decode();
            end
            for (int g = 0; g < BURST_GAP; g++) begin
                @(posedge CLK);
                instr_busy <= 1'b0;
                data_busy  <= 1'b0;
                random_decode();
            end
        end
    endtask

    task automatic load_use_cases();
        // lw x9 followed by a reader of x9
        @(posedge CLK);
        set_decode(1'b1, 5'd0, 5'd0, 5'd9, 1'b1, 1'b1);
        @(posedge CLK);
        set_decode(1'b1, 5'd9, 5'd3, 5'd4, 1'b1, 1'b0);
        repeat (2) @(posedge CLK);
        // Same pattern through x0
        set_decode(1'b1, 5'd0, 5'd0, 5'd0, 1'b1, 1'b1);
        @(posedge CLK);
        set_decode(1'b1, 5'd0, 5'd0, 5'd6, 1'b1, 1'b0);
        @(posedge CLK);
        clear_inputs();
    endtask

    task automatic jump_cases();
        @(posedge CLK);
        jump <= 1'b1;
        @(posedge CLK);
        jump       <= 1'b0;
        instr_busy <= 1'b1;
        repeat (3) @(posedge CLK);
        // Jump in the cycle the fetch comes back
        instr_busy <= 1'b0;
        jump       <= 1'b1;
        @(posedge CLK);
        jump <= 1'b0;
        @(posedge CLK);
    endtask

    task automatic forwarding_stream();
        logic [7:0] r;
        for (int i = 0; i < FWD_CYCLES; i++) begin
            @(posedge CLK);
            random_decode();
            r = take_bits(4);
            instr_busy <= (r == 8'd0);
            r = take_bits(4);
            data_busy <= (r == 8'd0);
            r = take_bits(3);
            jump <= (r == 8'd0);
        end
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge CLK);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        clear_inputs();
        wait (RSTn === 1'b1);
        repeat (IDLE_CYCLES) @(posedge CLK);
        stall_bursts();
        load_use_cases();
        jump_cases();
        forwarding_stream();
        @(posedge CLK);
        clear_inputs();
        repeat (IDLE_CYCLES) @(posedge CLK);
        @(negedge CLK);
        if ((n_load_use > 0) && (n_wait > 0) && (n_fwd_mem > 0) && (n_fwd_wb > 0)) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("Stimulus missed a case: load-use %0d, wait %0d, fwd mem %0d, fwd wb %0d",
                     n_load_use, n_wait, n_fwd_mem, n_fwd_wb);
            $display("TB FAILED");
            $fatal(1, "coverage hole");
        end
    end

endmodule

`default_nettype wire

// ==== verilog/forward_unit.sv ====
//**************************************
// Forward unit
// Selects the EX operand sources from
// the EX/MEM and MEM/WB writers
//**************************************
`include "riscv_ctrl_params.svh"
`default_nettype none

module forward_unit (
    input  riscv_pkg::reg_idx_t ex_rs1,
    input  riscv_pkg::reg_idx_t ex_rs2,
    input  riscv_pkg::reg_idx_t mem_rd,
    input  riscv_pkg::reg_idx_t wb_rd,
    input  logic                mem_wr,
    input  logic                wb_wr,
    output riscv_pkg::fwd_sel_t fwd_a,
    output riscv_pkg::fwd_sel_t fwd_b
);

    // EX/MEM wins, it holds the younger result
    function automatic riscv_pkg::fwd_sel_t pick_src(
        input riscv_pkg::reg_idx_t src,
        input riscv_pkg::reg_idx_t m_rd,
        input logic                m_wr,
        input riscv_pkg::reg_idx_t w_rd,
        input logic                w_wr
    );
        riscv_pkg::fwd_sel_t sel;
        sel = `FWD_REG;
        if (m_wr && (m_rd != '0) && (m_rd == src)) begin
            sel = `FWD_MEM;
        end else if (w_wr && (w_rd != '0) && (w_rd == src)) begin
            sel = `FWD_WB;
        end
        return sel;
    endfunction

    assign fwd_a = pick_src(ex_rs1, mem_rd, mem_wr, wb_rd, wb_wr);
    assign fwd_b = pick_src(ex_rs2, mem_rd, mem_wr, wb_rd, wb_wr);

endmodule

`default_nettype wire

// ==== verilog/hazard_unit.sv ====
//**************************************
// Hazard unit
// Memory-busy FSM, load-use detection and
// jump handling; drives the five stage
// controls and the memory request levels
//**************************************
`include "riscv_ctrl_params.svh"
`default_nettype none

module hazard_unit (
    input  logic                    CLK,
    input  logic                    RSTn,
    input  logic                    jump,
    input  logic                    instr_busy,
    input  logic                    data_busy,
    input  logic                    dec_valid,
    input  riscv_pkg::reg_idx_t     dec_rs1,
    input  riscv_pkg::reg_idx_t     dec_rs2,
    input  logic                    ex_load,
    input  riscv_pkg::reg_idx_t     ex_rd,
    output logic                    instr_req,
    output logic                    data_req,
    output riscv_pkg::hazard_ctrl_t pc_ctrl,
    output riscv_pkg::hazard_ctrl_t if_dec_ctrl,
    output riscv_pkg::hazard_ctrl_t dec_ex_ctrl,
    output riscv_pkg::hazard_ctrl_t ex_mem_ctrl,
    output riscv_pkg::hazard_ctrl_t mem_wb_ctrl
);

    typedef enum logic [1:0] {
        ST_ISSUE,
        ST_INSTR_WAIT,
        ST_DATA_WAIT,
        ST_BOTH_WAIT
    } hz_state_t;

    hz_state_t state;
    hz_state_t state_nxt;
    logic      load_use;
    logic      wait_busy;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            state <= ST_ISSUE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_ISSUE: begin
                if (instr_busy && data_busy) begin
                    state_nxt = ST_BOTH_WAIT;
                end else if (instr_busy) begin
                    state_nxt = ST_INSTR_WAIT;
                end else if (data_busy) begin
                    state_nxt = ST_DATA_WAIT;
                end
            end
            ST_INSTR_WAIT: begin
                if (!instr_busy) begin
                    state_nxt = ST_ISSUE;
                end
            end
            ST_DATA_WAIT: begin
                if (!data_busy) begin
                    state_nxt = ST_ISSUE;
                end
            end
            ST_BOTH_WAIT: begin
                // Instruction side is served first when both are pending
                if (instr_busy) begin
                    state_nxt = ST_INSTR_WAIT;
                end else if (data_busy) begin
                    state_nxt = ST_DATA_WAIT;
                end else begin
                    state_nxt = ST_ISSUE;
                end
            end
            default: state_nxt = ST_ISSUE;
        endcase
    end

    // Busy level that keeps the current wait state waiting
    always_comb begin
        case (state)
            ST_INSTR_WAIT: wait_busy = instr_busy;
            ST_DATA_WAIT:  wait_busy = data_busy;
            ST_BOTH_WAIT:  wait_busy = instr_busy || data_busy;
            default:       wait_busy = 1'b0;
        endcase
    end

    // Load in EX whose result is read by DEC; x0 never creates a dependency
    assign load_use = ex_load && (ex_rd != '0) && dec_valid &&
                      ((ex_rd == dec_rs1) || (ex_rd == dec_rs2));

    always_comb begin
        pc_ctrl     = `HZ_ENABLE;
        if_dec_ctrl = `HZ_ENABLE;
        dec_ex_ctrl = `HZ_ENABLE;
        ex_mem_ctrl = `HZ_ENABLE;
        mem_wb_ctrl = `HZ_ENABLE;
        instr_req   = 1'b1;
        data_req    = 1'b1;

        if (state == ST_ISSUE) begin
            if (instr_busy) begin
                pc_ctrl     = `HZ_STALL;
                if_dec_ctrl = `HZ_STALL;
                dec_ex_ctrl = `HZ_STALL;
                ex_mem_ctrl = `HZ_STALL;
                mem_wb_ctrl = `HZ_STALL;
            end else if (jump) begin
                // Drop the wrong-path fetch
                if_dec_ctrl = `HZ_FLUSH;
            end

            // Hold the consumer in DEC, send a bubble into EX
            if (load_use) begin
                pc_ctrl     = `HZ_STALL;
                if_dec_ctrl = `HZ_STALL;
                dec_ex_ctrl = `HZ_FLUSH;
            end
        end else if (wait_busy) begin
            instr_req   = 1'b0;
            data_req    = 1'b0;
            pc_ctrl     = `HZ_STALL;
            if_dec_ctrl = `HZ_STALL;
            dec_ex_ctrl = `HZ_STALL;
            ex_mem_ctrl = `HZ_STALL;
            mem_wb_ctrl = `HZ_STALL;
        end else if ((state == ST_INSTR_WAIT) && jump) begin
            // Fetch just returned on the wrong path, keep the jump target
            pc_ctrl     = `HZ_STALL;
            if_dec_ctrl = `HZ_FLUSH;
        end
    end

    // New requests are always issued from ISSUE
    a_req_in_issue: assert property (
        @(posedge CLK) disable iff (!RSTn)
        (state == ST_ISSUE) |-> (instr_req && data_req)
    );

    // At most one pipeline register is flushed per cycle
    a_single_flush: assert property (
        @(posedge CLK) disable iff (!RSTn)
        $countones({pc_ctrl == `HZ_FLUSH, if_dec_ctrl == `HZ_FLUSH,
                    dec_ex_ctrl == `HZ_FLUSH, ex_mem_ctrl == `HZ_FLUSH,
                    mem_wb_ctrl == `HZ_FLUSH}) <= 1
    );

endmodule

`default_nettype wire

// ==== verilog/pipe_ctrl_top.sv ====
//**************************************
// Pipeline control top level
// Hazard unit, descriptor tracker and
// forwarding unit of the five-stage core
//**************************************
`default_nettype none

module pipe_ctrl_top (
    input  logic                    CLK,
    input  logic                    RSTn,
    input  logic                    dec_valid,
    input  riscv_pkg::reg_idx_t     dec_rs1,
    input  riscv_pkg::reg_idx_t     dec_rs2,
    input  riscv_pkg::reg_idx_t     dec_rd,
    input  logic                    dec_reg_write,
    input  logic                    dec_is_load,
    input  logic                    jump,
    input  logic                    instr_busy,
    input  logic                    data_busy,
    output logic                    instr_req,
    output logic                    data_req,
    output riscv_pkg::hazard_ctrl_t pc_ctrl,
    output riscv_pkg::hazard_ctrl_t if_dec_ctrl,
    output riscv_pkg::hazard_ctrl_t dec_ex_ctrl,
    output riscv_pkg::hazard_ctrl_t ex_mem_ctrl,
    output riscv_pkg::hazard_ctrl_t mem_wb_ctrl,
    output riscv_pkg::fwd_sel_t     fwd_a,
    output riscv_pkg::fwd_sel_t     fwd_b
);

    // Tracked slot state
    logic                ex_load;
    riscv_pkg::reg_idx_t ex_rd;
    riscv_pkg::reg_idx_t ex_rs1;
    riscv_pkg::reg_idx_t ex_rs2;
    logic                mem_wr;
    logic                wb_wr;
    riscv_pkg::reg_idx_t mem_rd;
    riscv_pkg::reg_idx_t wb_rd;

    hazard_unit i_hazard (
        .CLK         (CLK),
        .RSTn        (RSTn),
        .jump        (jump),
        .instr_busy  (instr_busy),
        .data_busy   (data_busy),
        .dec_valid   (dec_valid),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .ex_load     (ex_load),
        .ex_rd       (ex_rd),
        .instr_req   (instr_req),
        .data_req    (data_req),
        .pc_ctrl     (pc_ctrl),
        .if_dec_ctrl (if_dec_ctrl),
        .dec_ex_ctrl (dec_ex_ctrl),
        .ex_mem_ctrl (ex_mem_ctrl),
        .mem_wb_ctrl (mem_wb_ctrl)
    );

    stage_tracker i_tracker (
        .CLK           (CLK),
        .RSTn          (RSTn),
        .dec_valid     (dec_valid),
        .dec_reg_write (dec_reg_write),
        .dec_is_load   (dec_is_load),
        .dec_rs1       (dec_rs1),
        .dec_rs2       (dec_rs2),
        .dec_rd        (dec_rd),
        .dec_ex_ctrl   (dec_ex_ctrl),
        .ex_mem_ctrl   (ex_mem_ctrl),
        .mem_wb_ctrl   (mem_wb_ctrl),
        .ex_load       (ex_load),
        .ex_rd         (ex_rd),
        .ex_rs1        (ex_rs1),
        .ex_rs2        (ex_rs2),
        .mem_wr        (mem_wr),
        .wb_wr         (wb_wr),
        .mem_rd        (mem_rd),
        .wb_rd         (wb_rd)
    );

    forward_unit i_forward (
        .ex_rs1 (ex_rs1),
        .ex_rs2 (ex_rs2),
        .mem_rd (mem_rd),
        .wb_rd  (wb_rd),
        .mem_wr (mem_wr),
        .wb_wr  (wb_wr),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b)
    );

endmodule

`default_nettype wire

// ==== verilog/riscv_ctrl_params.svh ====
//**************************************
// Pipeline control parameters
// Register index width, stage control
// codes and EX operand forwarding codes
//**************************************
`ifndef RISCV_CTRL_PARAMS_SVH
`define RISCV_CTRL_PARAMS_SVH

// Register index width (x0..x31)
`define RV_REG_W 5

// Stage register controls
`define HZ_ENABLE 2'b00
`define HZ_STALL  2'b01
`define HZ_FLUSH  2'b10

// EX operand sources
`define FWD_REG 2'b00
`define FWD_MEM 2'b01
`define FWD_WB  2'b10

`endif

// ==== verilog/riscv_pkg.sv ====
//**************************************
// Shared types for the pipeline control
// subsystem of the five-stage core
//**************************************
`include "riscv_ctrl_params.svh"
`default_nettype none

package riscv_pkg;

    // Architectural register index
    typedef logic [`RV_REG_W-1:0] reg_idx_t;

    // Per-stage register control, see HZ_* codes
    typedef logic [1:0] hazard_ctrl_t;

    // EX operand source select, see FWD_* codes
    typedef logic [1:0] fwd_sel_t;

endpackage

`default_nettype wire

// ==== verilog/stage_tracker.sv ====
//**************************************
// Stage tracker
// Register-usage descriptors of the
// DEC/EX, EX/MEM and MEM/WB slots,
// moved by the hazard stage controls
//**************************************
`include "riscv_ctrl_params.svh"
`default_nettype none

module stage_tracker (
    input  logic                    CLK,
    input  logic                    RSTn,
    input  logic                    dec_valid,
    input  logic                    dec_reg_write,
    input  logic                    dec_is_load,
    input  riscv_pkg::reg_idx_t     dec_rs1,
    input  riscv_pkg::reg_idx_t     dec_rs2,
    input  riscv_pkg::reg_idx_t     dec_rd,
    input  riscv_pkg::hazard_ctrl_t dec_ex_ctrl,
    input  riscv_pkg::hazard_ctrl_t ex_mem_ctrl,
    input  riscv_pkg::hazard_ctrl_t mem_wb_ctrl,
    output logic                    ex_load,
    output riscv_pkg::reg_idx_t     ex_rd,
    output riscv_pkg::reg_idx_t     ex_rs1,
    output riscv_pkg::reg_idx_t     ex_rs2,
    output logic                    mem_wr,
    output logic                    wb_wr,
    output riscv_pkg::reg_idx_t     mem_rd,
    output riscv_pkg::reg_idx_t     wb_rd
);

    // Valid bits
    logic ex_v;
    logic mem_v;
    logic wb_v;

    // Descriptor payload
    logic                ex_wr_q;
    logic                ex_ld_q;
    riscv_pkg::reg_idx_t ex_rs1_q;
    riscv_pkg::reg_idx_t ex_rs2_q;
    riscv_pkg::reg_idx_t ex_rd_q;
    logic                mem_wr_q;
    riscv_pkg::reg_idx_t mem_rd_q;
    logic                wb_wr_q;
    riscv_pkg::reg_idx_t wb_rd_q;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            ex_v  <= 1'b0;
            mem_v <= 1'b0;
            wb_v  <= 1'b0;
        end else begin
            case (dec_ex_ctrl)
                `HZ_ENABLE: ex_v <= dec_valid;
                `HZ_FLUSH:  ex_v <= 1'b0;
                default:    ex_v <= ex_v;
            endcase
            case (ex_mem_ctrl)
                `HZ_ENABLE: mem_v <= ex_v;
                `HZ_FLUSH:  mem_v <= 1'b0;
                default:    mem_v <= mem_v;
            endcase
            case (mem_wb_ctrl)
                `HZ_ENABLE: wb_v <= mem_v;
                `HZ_FLUSH:  wb_v <= 1'b0;
                default:    wb_v <= wb_v;
            endcase
        end
    end

    // Payload loads on ENABLE only
    always_ff @(posedge CLK) begin
        if (dec_ex_ctrl == `HZ_ENABLE) begin
            ex_wr_q  <= dec_reg_write;
            ex_ld_q  <= dec_is_load;
            ex_rs1_q <= dec_rs1;
            ex_rs2_q <= dec_rs2;
            ex_rd_q  <= dec_rd;
        end
        if (ex_mem_ctrl == `HZ_ENABLE) begin
            mem_wr_q <= ex_wr_q;
            mem_rd_q <= ex_rd_q;
        end
        if (mem_wb_ctrl == `HZ_ENABLE) begin
            wb_wr_q <= mem_wr_q;
            wb_rd_q <= mem_rd_q;
        end
    end

    // Bubbles read and write nothing
    assign ex_load = ex_v && ex_ld_q;
    assign ex_rd   = ex_v ? ex_rd_q : '0;
    assign ex_rs1  = ex_v ? ex_rs1_q : '0;
    assign ex_rs2  = ex_v ? ex_rs2_q : '0;
    assign mem_wr  = mem_v && mem_wr_q;
    assign mem_rd  = mem_v ? mem_rd_q : '0;
    assign wb_wr   = wb_v && wb_wr_q;
    assign wb_rd   = wb_v ? wb_rd_q : '0;

    // A bubble moving down the pipe reports no write
    a_mem_bubble_no_write: assert property (
        @(posedge CLK) disable iff (!RSTn)
        ((ex_mem_ctrl == `HZ_ENABLE) && !ex_v) |=> !mem_wr
    );

    a_wb_bubble_no_write: assert property (
        @(posedge CLK) disable iff (!RSTn)
        ((mem_wb_ctrl == `HZ_ENABLE) && !mem_v) |=> !wb_wr
    );

endmodule

`default_nettype wire
